// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_riscv
BUILD_DIR ?= obj_dir
FILE_LIST ?= files.f
LOG ?= sim.log
FAIL_MSG ?= Finished with errors
PASS_MSG ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) --binary --timing -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: decoder.sv
`default_nettype none

module decoder (
	input logic clk,
	input logic rst,
	input logic adv,
	input logic stall_front,
	input riscv_pkg::inst_t id_inst,
	input riscv_pkg::word_t id_pc,
	input logic id_valid,
	input riscv_pkg::word_t [31:0] regs_value,
	input logic ex_fwd_we,
	input riscv_pkg::reg_addr_t ex_fwd_rd,
	input riscv_pkg::word_t ex_fwd_data,
	input logic mem_fwd_we,
	input riscv_pkg::reg_addr_t mem_fwd_rd,
	input riscv_pkg::word_t mem_fwd_data,
	input logic wb_fwd_we,
	input riscv_pkg::reg_addr_t wb_fwd_rd,
	input riscv_pkg::word_t wb_fwd_data,
	output riscv_pkg::reg_addr_t rs1,
	output riscv_pkg::reg_addr_t rs2,
	output riscv_pkg::op_t ex_op,
	output riscv_pkg::word_t ex_a,
	output riscv_pkg::word_t ex_b,
	output riscv_pkg::word_t ex_store_data,
	output riscv_pkg::reg_addr_t ex_rd,
	output logic ex_we,
	output logic ex_load,
	output logic ex_store,
	output riscv_pkg::inst_t ex_inst,
	output riscv_pkg::word_t ex_pc,
	output logic ex_valid
);
	import riscv_pkg::*;

	op_t op;
	word_t b;
	word_t rs1_val;
	word_t rs2_val;
	word_t imm_i;
	word_t imm_s;
	word_t imm_u;
	logic we;
	logic load;
	logic store;
	logic use_rs1;
	logic use_rs2;

	// youngest producer wins
	function automatic word_t read_src(input reg_addr_t addr);
		word_t val;
		if (addr == '0)
			val = '0;
		else if (ex_fwd_we && ex_fwd_rd == addr)
			val = ex_fwd_data;
		else if (mem_fwd_we && mem_fwd_rd == addr)
			val = mem_fwd_data;
		else if (wb_fwd_we && wb_fwd_rd == addr)
			val = wb_fwd_data;
		else
			val = regs_value[addr];
		return val;
	endfunction

	assign imm_i = {{20{id_inst.i.imm[11]}}, id_inst.i.imm};
	assign imm_s = {{20{id_inst.r.funct7[6]}}, id_inst.r.funct7, id_inst.i.rd};
	assign imm_u = {id_inst.r.funct7, id_inst.r.rs2, id_inst.r.rs1, id_inst.r.funct3, 12'b0};
	assign rs1 = use_rs1 ? id_inst.r.rs1 : '0; // unused fields must not raise a stall
	assign rs2 = use_rs2 ? id_inst.r.rs2 : '0;

	always_comb begin
		rs1_val = read_src(id_inst.r.rs1);
		rs2_val = read_src(id_inst.r.rs2);
	end

	always_comb begin
		op = alu_add;
		b = imm_i;
		we = 1'b0;
		load = 1'b0;
		store = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		if (id_valid) begin
			case (id_inst.r.opcode)
				op_reg, op_imm: begin
					use_rs1 = 1'b1;
					use_rs2 = id_inst.r.opcode == op_reg;
					we = 1'b1;
					if (id_inst.r.opcode == op_reg)
						b = rs2_val;
					case (id_inst.r.funct3)
						f3_add_sub: op = (id_inst.r.opcode == op_reg && id_inst.r.funct7[5]) ?
							alu_sub : alu_add;
						f3_xor: op = alu_xor;
						f3_or: op = alu_or;
						f3_and: op = alu_and;
						default: we = 1'b0; // shifts and compares retire as no-ops
					endcase
				end
				op_lui: begin
					op = alu_pass_b;
					b = imm_u;
					we = 1'b1;
				end
				op_load: begin
					use_rs1 = id_inst.r.funct3 == f3_word;
					we = use_rs1;
					load = use_rs1;
				end
				op_store: begin
					use_rs1 = id_inst.r.funct3 == f3_word;
					use_rs2 = use_rs1;
					store = use_rs1;
					b = imm_s;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ex_valid <= 1'b0;
			ex_we <= 1'b0;
			ex_load <= 1'b0;
			ex_store <= 1'b0;
			ex_inst <= nop_inst;
		end else if (adv) begin
			ex_valid <= id_valid & ~stall_front; // bubble while the load resolves
			ex_we <= we & ~stall_front;
			ex_load <= load & ~stall_front;
			ex_store <= store & ~stall_front;
			ex_inst <= stall_front ? nop_inst : id_inst;
		end
	end

	always_ff @(posedge clk) begin
		if (adv) begin
			ex_op <= op;
			ex_a <= rs1_val;
			ex_b <= b;
			ex_store_data <= rs2_val;
			ex_rd <= we ? id_inst.r.rd : '0;
			ex_pc <= id_pc;
		end
	end

endmodule

`default_nettype wire

// File: execute.sv
`default_nettype none

module execute (
	input logic clk,
	input logic rst,
	input logic adv,
	input riscv_pkg::op_t ex_op,
	input riscv_pkg::word_t ex_a,
	input riscv_pkg::word_t ex_b,
	input riscv_pkg::word_t ex_store_data,
	input riscv_pkg::reg_addr_t ex_rd,
	input logic ex_we,
	input logic ex_load,
	input logic ex_store,
	input riscv_pkg::inst_t ex_inst,
	input riscv_pkg::word_t ex_pc,
	input logic ex_valid,
	output logic ex_fwd_we,
	output riscv_pkg::reg_addr_t ex_fwd_rd,
	output riscv_pkg::word_t ex_fwd_data,
	output riscv_pkg::word_t mem_addr_or_result,
	output riscv_pkg::word_t mem_store_data,
	output riscv_pkg::reg_addr_t mem_rd,
	output logic mem_we,
	output logic mem_load,
	output logic mem_store,
	output riscv_pkg::inst_t mem_inst,
	output riscv_pkg::word_t mem_pc,
	output logic mem_valid
);
	import riscv_pkg::*;

	word_t result;

	always_comb begin
		case (ex_op)
			alu_sub: result = ex_a - ex_b;
			alu_and: result = ex_a & ex_b;
			alu_or: result = ex_a | ex_b;
			alu_xor: result = ex_a ^ ex_b;
			alu_pass_b: result = ex_b;
			default: result = ex_a + ex_b; // also the lw/sw address
		endcase
	end

	assign ex_fwd_we = ex_valid & ex_we & ~ex_load; // load data is not here yet
	assign ex_fwd_rd = ex_rd;
	assign ex_fwd_data = result;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mem_valid <= 1'b0;
			mem_we <= 1'b0;
			mem_load <= 1'b0;
			mem_store <= 1'b0;
			mem_inst <= nop_inst;
		end else if (adv) begin
			mem_valid <= ex_valid;
			mem_we <= ex_we;
			mem_load <= ex_load;
			mem_store <= ex_store;
			mem_inst <= ex_inst;
		end
	end

	always_ff @(posedge clk) begin
		if (adv) begin
			mem_addr_or_result <= result;
			mem_store_data <= ex_store_data;
			mem_rd <= ex_rd;
			mem_pc <= ex_pc;
		end
	end

endmodule

`default_nettype wire

// File: fetch.sv
`default_nettype none

module fetch #(
	parameter riscv_pkg::word_t reset_pc = 32'h8000_0000
) (
	input logic clk,
	input logic rst,
	input logic adv,
	input logic stall_front,
	input logic iresp_data_ok,
	input riscv_pkg::word_t iresp_data,
	output logic ireq_valid,
	output riscv_pkg::word_t ireq_addr,
	output riscv_pkg::word_t pc,
	output logic fetch_ok,
	output riscv_pkg::inst_t id_inst,
	output riscv_pkg::word_t id_pc,
	output logic id_valid
);
	import riscv_pkg::*;

	word_t buf_word;
	logic buf_valid;
	word_t cur_word;

	assign ireq_addr = pc;
	assign fetch_ok = buf_valid | (ireq_valid & iresp_data_ok);
	assign cur_word = buf_valid ? buf_word : iresp_data; // bypass the buffer on a same-cycle hit

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= reset_pc;
			ireq_valid <= 1'b0;
			buf_valid <= 1'b0;
			id_valid <= 1'b0;
			id_inst <= nop_inst;
		end else if (adv && !stall_front) begin
			id_inst <= cur_word;
			id_pc <= pc;
			id_valid <= 1'b1;
			pc <= pc + 32'd4;
			buf_valid <= 1'b0;
			ireq_valid <= 1'b1; // next word right away
		end else if (ireq_valid && iresp_data_ok) begin
			buf_word <= iresp_data;
			buf_valid <= 1'b1;
			ireq_valid <= 1'b0;
		end else if (!ireq_valid && !buf_valid) begin
			ireq_valid <= 1'b1; // first request out of reset
		end
	end

endmodule

`default_nettype wire

// File: files.f
riscv_pkg.sv
regs.sv
fetch.sv
decoder.sv
execute.sv
memory.sv
pipeline_ctrl.sv
riscv.sv
tb_mem.sv
tb_riscv.sv

// File: memory.sv
`default_nettype none

module memory (
	input logic clk,
	input logic rst,
	input logic adv,
	input riscv_pkg::word_t mem_addr_or_result,
	input riscv_pkg::word_t mem_store_data,
	input riscv_pkg::reg_addr_t mem_rd,
	input logic mem_we,
	input logic mem_load,
	input logic mem_store,
	input riscv_pkg::inst_t mem_inst,
	input riscv_pkg::word_t mem_pc,
	input logic mem_valid,
	input logic dresp_data_ok,
	input riscv_pkg::word_t dresp_rdata,
	output logic dreq_valid,
	output logic dreq_write,
	output riscv_pkg::word_t dreq_addr,
	output riscv_pkg::word_t dreq_wdata,
	output logic mem_ok,
	output logic mem_fwd_we,
	output riscv_pkg::reg_addr_t mem_fwd_rd,
	output riscv_pkg::word_t mem_fwd_data,
	output logic wb_we,
	output riscv_pkg::reg_addr_t wb_rd,
	output riscv_pkg::word_t wb_data,
	output riscv_pkg::inst_t wb_inst,
	output riscv_pkg::word_t wb_pc,
	output logic wb_valid
);
	import riscv_pkg::*;

	logic access;
	logic done; // access finished while the pipe was held
	word_t held_data;
	word_t load_data;

	assign access = mem_valid & (mem_load | mem_store);
	assign dreq_valid = access & ~done;
	assign dreq_write = mem_store;
	assign dreq_addr = mem_addr_or_result;
	assign dreq_wdata = mem_store_data;
	assign mem_ok = ~access | done | dresp_data_ok;
	assign load_data = done ? held_data : dresp_rdata;

	assign mem_fwd_we = mem_valid & mem_we;
	assign mem_fwd_rd = mem_rd;
	assign mem_fwd_data = mem_load ? load_data : mem_addr_or_result;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			done <= 1'b0;
		else if (adv)
			done <= 1'b0;
		else if (dreq_valid && dresp_data_ok)
			done <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (dreq_valid && dresp_data_ok)
			held_data <= dresp_rdata;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_we <= 1'b0;
			wb_inst <= nop_inst;
		end else if (adv) begin
			wb_valid <= mem_valid;
			wb_we <= mem_fwd_we;
			wb_inst <= mem_inst;
		end
	end

	always_ff @(posedge clk) begin
		if (adv) begin
			wb_rd <= mem_rd;
			wb_data <= mem_fwd_data;
			wb_pc <= mem_pc;
		end
	end

endmodule

`default_nettype wire

// File: pipeline_ctrl.sv
`default_nettype none

module pipeline_ctrl (
	input logic fetch_ok,
	input logic mem_ok,
	input riscv_pkg::reg_addr_t rs1,
	input riscv_pkg::reg_addr_t rs2,
	input logic ex_load,
	input riscv_pkg::reg_addr_t ex_rd,
	input logic ex_valid,
	output logic adv,
	output logic stall_front
);
	import riscv_pkg::*;

	logic load_use;

	// rs1/rs2 come in as x0 when the field is not a source
	assign load_use = ex_valid & ex_load & (ex_rd != '0) & (ex_rd == rs1 || ex_rd == rs2);

	assign adv = fetch_ok & mem_ok;
	assign stall_front = adv & load_use;

endmodule

`default_nettype wire

// File: regs.sv
`default_nettype none

module regs (
	input logic clk,
	input logic rst,
	input logic we,
	input riscv_pkg::reg_addr_t waddr,
	input riscv_pkg::word_t wdata,
	output riscv_pkg::word_t [31:0] regs_value
);
	import riscv_pkg::*;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			regs_value <= '0;
		end else if (we && waddr != '0) begin // x0 stays zero
			regs_value[waddr] <= wdata;
		end
	end

endmodule

`default_nettype wire

// File: riscv.sv
`default_nettype none

module riscv #(
	parameter riscv_pkg::word_t reset_pc = 32'h8000_0000
) (
	input logic clk,
	input logic rst,
	output logic ireq_valid,
	output riscv_pkg::word_t ireq_addr,
	input logic iresp_data_ok,
	input riscv_pkg::word_t iresp_data,
	output logic dreq_valid,
	output logic dreq_write,
	output riscv_pkg::word_t dreq_addr,
	output riscv_pkg::word_t dreq_wdata,
	input logic dresp_data_ok,
	input riscv_pkg::word_t dresp_rdata,
	output riscv_pkg::word_t pc,
	output riscv_pkg::word_t [31:0] regs,
	output logic reg_write_enable,
	output riscv_pkg::reg_addr_t reg_dest_addr,
	output riscv_pkg::word_t reg_write_data,
	output logic valid,
	output riscv_pkg::inst_t inst,
	output riscv_pkg::word_t inst_pc
);
	import riscv_pkg::*;

	logic adv;
	logic stall_front;
	logic fetch_ok;
	logic mem_ok;

	inst_t id_inst;
	word_t id_pc;
	logic id_valid;
	reg_addr_t rs1;
	reg_addr_t rs2;

	op_t ex_op;
	word_t ex_a;
	word_t ex_b;
	word_t ex_store_data;
	reg_addr_t ex_rd;
	logic ex_we;
	logic ex_load;
	logic ex_store;
	inst_t ex_inst;
	word_t ex_pc;
	logic ex_valid;

	word_t mem_addr_or_result;
	word_t mem_store_data;
	reg_addr_t mem_rd;
	logic mem_we;
	logic mem_load;
	logic mem_store;
	inst_t mem_inst;
	word_t mem_pc;
	logic mem_valid;

	logic wb_we;
	reg_addr_t wb_rd;
	word_t wb_data;
	inst_t wb_inst;
	word_t wb_pc;
	logic wb_valid;

	logic ex_fwd_we;
	reg_addr_t ex_fwd_rd;
	word_t ex_fwd_data;
	logic mem_fwd_we;
	reg_addr_t mem_fwd_rd;
	word_t mem_fwd_data;

	// commit only on the cycle the pipe moves
	assign valid = wb_valid & adv;
	assign inst = wb_inst;
	assign inst_pc = wb_pc;
	assign reg_write_enable = valid & wb_we & (wb_rd != '0);
	assign reg_dest_addr = wb_rd;
	assign reg_write_data = wb_data;

	regs u_regs (
		.clk(clk),
		.rst(rst),
		.we(reg_write_enable),
		.waddr(reg_dest_addr),
		.wdata(reg_write_data),
		.regs_value(regs)
	);

	fetch #(
		.reset_pc(reset_pc)
	) u_fetch (
		.*
	);

	decoder u_decoder (
		.regs_value(regs),
		.wb_fwd_we(wb_we),
		.wb_fwd_rd(wb_rd),
		.wb_fwd_data(wb_data),
		.*
	);

	execute u_execute (.*);

	memory u_memory (.*);

	pipeline_ctrl u_pipeline_ctrl (.*);

endmodule

`default_nettype wire

// File: riscv_pkg.sv
`default_nettype none

package riscv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_addr_t rs2;
			reg_addr_t rs1;
			logic [2:0] funct3;
			reg_addr_t rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			reg_addr_t rs1;
			logic [2:0] funct3;
			reg_addr_t rd;
			logic [6:0] opcode;
		} i;
	} inst_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b
	} op_t;

	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	localparam logic [2:0] f3_word = 3'b010; // lw / sw

	localparam word_t nop_inst = 32'h0000_0013; // addi x0,x0,0

endpackage

`default_nettype wire

// File: tb_mem.sv
`default_nettype none

module tb_mem #(
	parameter logic [31:0] code_base = 32'h8000_0000
) (
	input logic clk,
	input logic rst,
	input logic ireq_valid,
	input logic [31:0] ireq_addr,
	output logic iresp_data_ok,
	output logic [31:0] iresp_data,
	input logic dreq_valid,
	input logic dreq_write,
	input logic [31:0] dreq_addr,
	input logic [31:0] dreq_wdata,
	output logic dresp_data_ok,
	output logic [31:0] dresp_rdata
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] imem [0:63]; // filled by the testbench top
	logic [31:0] dmem [0:15];
	logic [31:0] lcg_state;
	logic i_pend;
	logic d_pend;
	int i_wait;
	int d_wait;

	function int next_latency();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'({30'd0, lcg_state[29:28]}); // 0 to 3 cycles
	endfunction

	function logic [31:0] read_code(input logic [31:0] addr);
		logic [31:0] ofs;
		ofs = addr - code_base;
		if (ofs[31:8] == 24'd0)
			return imem[ofs[7:2]];
		return 32'h0000_0013; // nop past the program
	endfunction

	initial begin
		for (int k = 0; k < 16; k++)
			dmem[k] = 32'd0;
		lcg_state = 32'h100e2383;
		i_pend = 1'b0;
		d_pend = 1'b0;
		i_wait = 0;
		d_wait = 0;
		iresp_data_ok = 1'b0;
		iresp_data = 32'd0;
		dresp_data_ok = 1'b0;
		dresp_rdata = 32'd0;
	end

	// one pulse per request; the core never keeps a request up after a pulse
	always begin
		@(posedge clk);
		#1;
		iresp_data_ok = 1'b0;
		dresp_data_ok = 1'b0;
		if (rst) begin
			i_pend = 1'b0;
			d_pend = 1'b0;
		end else begin
			if (ireq_valid) begin
				if (!i_pend) begin
					i_pend = 1'b1;
					i_wait = next_latency();
				end
				if (i_wait == 0) begin
					iresp_data_ok = 1'b1;
					iresp_data = read_code(ireq_addr);
					i_pend = 1'b0;
				end else begin
					i_wait--;
				end
			end
			if (dreq_valid) begin
				if (!d_pend) begin
					d_pend = 1'b1;
					d_wait = next_latency();
				end
				if (d_wait == 0) begin
					dresp_data_ok = 1'b1;
					if (dreq_write)
						dmem[dreq_addr[5:2]] = dreq_wdata;
					else
						dresp_rdata = dmem[dreq_addr[5:2]];
					d_pend = 1'b0;
				end else begin
					d_wait--;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_riscv.sv
`default_nettype none

module tb_riscv;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] base_pc = 32'h8000_0000;
	localparam int n_inst = 19;
	localparam int commit_timeout = 100;

	logic clk;
	logic rst;
	logic ireq_valid;
	logic [31:0] ireq_addr;
	logic iresp_data_ok;
	logic [31:0] iresp_data;
	logic dreq_valid;
	logic dreq_write;
	logic [31:0] dreq_addr;
	logic [31:0] dreq_wdata;
	logic dresp_data_ok;
	logic [31:0] dresp_rdata;
	logic [31:0] pc;
	logic [31:0][31:0] regs;
	logic reg_write_enable;
	logic [4:0] reg_dest_addr;
	logic [31:0] reg_write_data;
	logic valid;
	logic [31:0] inst;
	logic [31:0] inst_pc;

	logic [31:0] prog_word [0:n_inst-1];
	logic exp_we [0:n_inst-1];
	logic [4:0] exp_rd [0:n_inst-1];
	logic [31:0] exp_data [0:n_inst-1];
	logic [31:0] exp_regs [0:31];
	int n_entries;
	int errors;
	int cnt;
	logic hung;

	riscv #(
		.reset_pc(base_pc)
	) i_dut (
		.*
	);

	tb_mem #(
		.code_base(base_pc)
	) i_mem (
		.*
	);

	always #5 clk = ~clk;

	function logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function logic [31:0] enc_i(input logic [6:0] opc, input logic [11:0] imm,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	task add_entry(input logic [31:0] word, input logic we, input logic [4:0] rd,
			input logic [31:0] data);
		prog_word[n_entries] = word;
		exp_we[n_entries] = we;
		exp_rd[n_entries] = rd;
		exp_data[n_entries] = data;
		n_entries++;
	endtask

	// expected results follow sequential RV32I execution
	task build_program();
		n_entries = 0;
		add_entry(enc_i(7'b0010011, 12'd5, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, 32'h0000_0005);
		add_entry(enc_i(7'b0010011, 12'hffd, 5'd0, 3'b000, 5'd2), 1'b1, 5'd2, 32'hffff_fffd);
		add_entry(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 5'd3, 32'h0000_0002);
		add_entry(enc_r(7'h20, 5'd3, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, 32'h0000_0003);
		add_entry(enc_r(7'h00, 5'd2, 5'd4, 3'b100, 5'd5), 1'b1, 5'd5, 32'hffff_fffe);
		add_entry(enc_r(7'h00, 5'd1, 5'd5, 3'b110, 5'd6), 1'b1, 5'd6, 32'hffff_ffff);
		add_entry(enc_r(7'h00, 5'd4, 5'd6, 3'b111, 5'd7), 1'b1, 5'd7, 32'h0000_0003);
		add_entry({20'h12345, 5'd8, 7'b0110111}, 1'b1, 5'd8, 32'h1234_5000);
		add_entry(enc_i(7'b0010011, 12'h678, 5'd8, 3'b110, 5'd8), 1'b1, 5'd8, 32'h1234_5678);
		add_entry(enc_i(7'b0010011, 12'hfff, 5'd8, 3'b100, 5'd9), 1'b1, 5'd9, 32'hedcb_a987);
		add_entry(enc_i(7'b0010011, 12'h0ff, 5'd9, 3'b111, 5'd10), 1'b1, 5'd10, 32'h0000_0087);
		add_entry(enc_s(12'd16, 5'd8, 5'd0), 1'b0, 5'd0, 32'd0);
		add_entry(enc_i(7'b0000011, 12'd16, 5'd0, 3'b010, 5'd11), 1'b1, 5'd11, 32'h1234_5678);
		add_entry(enc_r(7'h00, 5'd1, 5'd11, 3'b000, 5'd12), 1'b1, 5'd12, 32'h1234_567d);
		add_entry(enc_i(7'b0010011, 12'd7, 5'd1, 3'b000, 5'd0), 1'b0, 5'd0, 32'd0); // rd is x0
		add_entry(enc_s(12'd20, 5'd12, 5'd0), 1'b0, 5'd0, 32'd0);
		add_entry(enc_i(7'b0000011, 12'd20, 5'd0, 3'b010, 5'd13), 1'b1, 5'd13, 32'h1234_567d);
		add_entry(enc_r(7'h20, 5'd11, 5'd13, 3'b000, 5'd14), 1'b1, 5'd14, 32'h0000_0005);
		add_entry(enc_r(7'h00, 5'd13, 5'd14, 3'b000, 5'd15), 1'b1, 5'd15, 32'h1234_5682);
		for (int k = 0; k < 64; k++)
			i_mem.imem[k] = (k < n_entries) ? prog_word[k] : 32'h0000_0013;
		for (int k = 0; k < 32; k++)
			exp_regs[k] = 32'd0;
		for (int k = 0; k < n_entries; k++)
			if (exp_we[k])
				exp_regs[exp_rd[k]] = exp_data[k];
	endtask

	task check_word(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			errors++;
			$display("[FAIL] %s got %08h expected %08h", name, got, want);
		end
	endtask

	task end_run();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	// writes to x0 must never show on the commit port
	always @(negedge clk) begin
		if (!rst && reg_write_enable && (reg_dest_addr == 5'd0 || !valid)) begin
			errors++;
			$display("write enable raised for x0 or outside a commit at %0t", $time);
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		errors = 0;
		hung = 1'b0;
		build_program();
		repeat (16) @(posedge clk);
		#1;
		check_word("valid", {31'd0, valid}, 32'd0);
		check_word("reg_write_enable", {31'd0, reg_write_enable}, 32'd0);
		check_word("ireq_valid", {31'd0, ireq_valid}, 32'd0);
		check_word("dreq_valid", {31'd0, dreq_valid}, 32'd0);
		check_word("pc", pc, base_pc);
		for (int k = 0; k < 32; k++)
			check_word($sformatf("regs[%0d]", k), regs[k], 32'd0);
		rst = 1'b0;

		for (int k = 0; k < n_entries; k++) begin
			cnt = 0;
			do begin
				@(negedge clk);
				cnt++;
			end while (!valid && cnt < commit_timeout);
			if (!valid) begin
				errors++;
				hung = 1'b1;
				$display("timeout waiting for commit %0d", k);
				break;
			end
			check_word("inst_pc", inst_pc, base_pc + 32'(4 * k));
			check_word("inst", inst, prog_word[k]);
			check_word("reg_write_enable", {31'd0, reg_write_enable}, {31'd0, exp_we[k]});
			if (exp_we[k]) begin
				check_word("reg_dest_addr", {27'd0, reg_dest_addr}, {27'd0, exp_rd[k]});
				check_word("reg_write_data", reg_write_data, exp_data[k]);
			end
		end

		if (!hung) begin
			repeat (5) @(negedge clk);
			for (int k = 0; k < 32; k++)
				check_word($sformatf("regs[%0d]", k), regs[k], exp_regs[k]);
		end
		end_run();
	end

endmodule

`default_nettype wire
